// File: include/fsq_defines.svh
`ifndef FSQ_DEFINES_SVH
`define FSQ_DEFINES_SVH

// ring geometry
`define FSQ_SIZE 16
`define FSQ_WIDTH 4

// fetch addresses
`define VADDR_SIZE 32

// instruction offset inside one fetch block, up to eight instructions
`define PREDICTION_WIDTH 3

// back-end commit bandwidth
`define COMMIT_WIDTH 4
`define COMMIT_NUM_WIDTH 3

// committed but not yet retired instructions
`define COMMIT_ACC_WIDTH 8

`endif

// File: source/fsq_pkg.sv
`include "fsq_defines.svh"

package fsq_pkg;

    // wrap bit above the index so that a plain +1 flips it on wrap
    typedef struct packed {
        logic                  wrap;
        logic [`FSQ_WIDTH-1:0] idx;
    } fsq_idx_t;

    typedef struct packed {
        logic [`VADDR_SIZE-1:0]       start_addr;
        logic [`PREDICTION_WIDTH-1:0] size;
        logic [`VADDR_SIZE-1:0]       target;
        logic                         taken;
    } fetch_stream_t;

    typedef enum logic [1:0] {
        redir_none,
        redir_branch,
        redir_csr,
        redir_mem
    } redirect_kind_e;

    typedef enum logic [2:0] {
        br_direct,
        br_condition,
        br_indirect,
        br_call,
        br_ret
    } br_type_e;

    typedef struct packed {
        logic                         pred_error;
        logic                         taken;
        br_type_e                     br_type;
        logic [`PREDICTION_WIDTH-1:0] offset;
        logic [`VADDR_SIZE-1:0]       target;
    } wb_info_t;

    // record sent back to the predictor
    typedef struct packed {
        logic [`VADDR_SIZE-1:0]       start_addr;
        logic [`VADDR_SIZE-1:0]       target;
        logic                         taken;
        logic                         pred_error;
        br_type_e                     br_type;
        logic [`PREDICTION_WIDTH-1:0] offset;
    } update_t;

endpackage

// File: source/fsq_stream_ram.sv
`timescale 1ns/1ps
`include "fsq_defines.svh"

module fsq_stream_ram import fsq_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  we,
    input  logic [`FSQ_WIDTH-1:0] waddr,
    input  fetch_stream_t         wdata,
    input  logic [`FSQ_WIDTH-1:0] search_addr,
    input  logic [`FSQ_WIDTH-1:0] commit_addr,
    output fetch_stream_t         search_stream,
    output fetch_stream_t         commit_stream
);

    fetch_stream_t mem [`FSQ_SIZE];

    // predicted blocks land at the tail
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `FSQ_SIZE; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // search port also serves the refetch address of a memory redirect
    assign search_stream = mem[search_addr];

    // retiring block
    assign commit_stream = mem[commit_addr];

endmodule

// File: source/fsq_pointers.sv
`timescale 1ns/1ps
`include "fsq_defines.svh"

module fsq_pointers import fsq_pkg::*; (
    input  logic           clk,
    input  logic           rst,
    input  logic           enq,
    input  logic           issue_ok,
    input  logic           retire,
    input  redirect_kind_e redirect_kind,
    input  fsq_idx_t       redirect_idx,
    output fsq_idx_t       tail,
    output fsq_idx_t       search,
    output fsq_idx_t       head,
    output logic           full,
    output logic           search_valid,
    output logic           head_valid
);

    fsq_idx_t tail_n1;
    fsq_idx_t search_n1;
    fsq_idx_t head_n1;
    fsq_idx_t redirect_n1;
    logic     refetch_next;

    // wrap bit sits on top, so the carry out of idx flips it
    assign tail_n1     = fsq_idx_t'(tail + 1'b1);
    assign search_n1   = fsq_idx_t'(search + 1'b1);
    assign head_n1     = fsq_idx_t'(head + 1'b1);
    assign redirect_n1 = fsq_idx_t'(redirect_idx + 1'b1);

    // branch and csr resume after the redirected block
    assign refetch_next = (redirect_kind == redir_branch) || (redirect_kind == redir_csr);

    assign full         = (head.idx == tail.idx) && (head.wrap != tail.wrap);
    assign search_valid = search != tail;
    assign head_valid   = (head.idx != tail.idx) || full;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tail <= '0;
        end else if (redirect_kind != redir_none) begin
            tail <= redirect_n1;
        end else if (enq && !full) begin
            tail <= tail_n1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            search <= '0;
        end else if (refetch_next) begin
            search <= redirect_n1;
        end else if (redirect_kind == redir_mem) begin
            // memory refetch replays the same block
            search <= redirect_idx;
        end else if (issue_ok) begin
            search <= search_n1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head <= '0;
        end else if (retire) begin
            head <= head_n1;
        end
    end

endmodule

// File: source/fsq_fetch_issue.sv
`timescale 1ns/1ps
`include "fsq_defines.svh"

module fsq_fetch_issue import fsq_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  fsq_idx_t      search,
    input  logic          search_valid,
    input  fetch_stream_t search_stream,
    input  logic          cache_ready,
    input  logic          ibuf_full,
    input  logic          flush,
    output logic          cache_en,
    output fetch_stream_t cache_stream,
    output fsq_idx_t      cache_fsq_idx,
    output logic          issue_ok,
    output logic          cache_flush
);

    logic accepted;
    logic load;

    assign accepted = cache_en && cache_ready && !ibuf_full;

    // refill when the slot frees up, is idle, or gets flushed
    assign load = accepted || !cache_en || flush;

    // search moves once its entry is captured here
    assign issue_ok = load && search_valid && !flush;

    assign cache_flush = flush;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cache_en <= 1'b0;
        end else if (load) begin
            cache_en <= search_valid && !flush;
        end
    end

    // held while the cache or ibuf stalls
    always_ff @(posedge clk) begin
        if (load) begin
            cache_stream  <= search_stream;
            cache_fsq_idx <= search;
        end
    end

endmodule

// File: source/fsq_commit.sv
`timescale 1ns/1ps
`include "fsq_defines.svh"

module fsq_commit import fsq_pkg::*; (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         enq,
    input  logic [`FSQ_WIDTH-1:0]        enq_idx,
    input  redirect_kind_e               redirect_kind,
    input  fsq_idx_t                     redirect_idx,
    input  logic [`PREDICTION_WIDTH-1:0] redirect_offset,
    input  logic                         redirect_taken,
    input  logic [`VADDR_SIZE-1:0]       redirect_target,
    input  br_type_e                     redirect_br_type,
    input  logic [`COMMIT_NUM_WIDTH-1:0] commit_num,
    input  fsq_idx_t                     head,
    input  logic                         head_valid,
    input  fetch_stream_t                commit_stream,
    output logic                         retire,
    output logic                         update_valid,
    output update_t                      update_info
);

    localparam logic [`COMMIT_NUM_WIDTH-1:0] max_commit = `COMMIT_WIDTH;

    wb_info_t                     wb_tab [`FSQ_SIZE];
    wb_info_t                     head_wb;
    logic                         redir_error;
    logic [`PREDICTION_WIDTH-1:0] last_off;
    logic [`PREDICTION_WIDTH:0]   blk_num;
    logic [`COMMIT_NUM_WIDTH-1:0] commit_add;
    logic [`COMMIT_ACC_WIDTH-1:0] acc;
    logic [`COMMIT_ACC_WIDTH-1:0] add_ext;
    logic [`COMMIT_ACC_WIDTH-1:0] sub_ext;

    assign redir_error = (redirect_kind == redir_branch) || (redirect_kind == redir_csr);

    // write-back info, redirect wins over the clear
    always_ff @(posedge clk) begin
        if (enq) begin
            wb_tab[enq_idx] <= '0;
        end
        if (redirect_kind != redir_none) begin
            wb_tab[redirect_idx.idx] <= '{
                pred_error: redir_error,
                taken:      redirect_taken,
                br_type:    redirect_br_type,
                offset:     redirect_offset,
                target:     redirect_target
            };
        end
    end

    assign head_wb = wb_tab[head.idx];

    // a mispredicted block ends at the redirecting instruction
    assign last_off = head_wb.pred_error ? head_wb.offset : commit_stream.size;
    assign blk_num  = {1'b0, last_off} + 1'b1;

    assign commit_add = (commit_num > max_commit) ? max_commit : commit_num;
    assign retire     = head_valid && (acc > last_off);

    assign add_ext = {{(`COMMIT_ACC_WIDTH-`COMMIT_NUM_WIDTH){1'b0}}, commit_add};
    assign sub_ext = retire ? {{(`COMMIT_ACC_WIDTH-`PREDICTION_WIDTH-1){1'b0}}, blk_num} : '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc          <= '0;
            update_valid <= 1'b0;
        end else begin
            acc          <= acc + add_ext - sub_ext;
            update_valid <= retire;
        end
    end

    always_ff @(posedge clk) begin
        update_info.start_addr <= commit_stream.start_addr;
        update_info.pred_error <= head_wb.pred_error;
        if (head_wb.pred_error) begin
            update_info.target  <= head_wb.target;
            update_info.taken   <= head_wb.taken;
            update_info.br_type <= head_wb.br_type;
            update_info.offset  <= head_wb.offset;
        end else begin
            update_info.target  <= commit_stream.target;
            update_info.taken   <= commit_stream.taken;
            update_info.br_type <= br_direct;
            update_info.offset  <= commit_stream.size;
        end
    end

endmodule

// File: source/fsq.sv
`timescale 1ns/1ps
`include "fsq_defines.svh"

module fsq import fsq_pkg::*; (
    input  logic                         clk,
    input  logic                         rst,
    // predictor
    input  logic                         bpu_en,
    input  fetch_stream_t                bpu_stream,
    output logic                         bpu_stall,
    output fsq_idx_t                     bpu_stream_idx,
    // icache
    output logic                         cache_en,
    output fetch_stream_t                cache_stream,
    output fsq_idx_t                     cache_fsq_idx,
    output logic                         cache_flush,
    input  logic                         cache_ready,
    input  logic                         ibuf_full,
    // back end
    input  redirect_kind_e               redirect_kind,
    input  fsq_idx_t                     redirect_idx,
    input  logic [`PREDICTION_WIDTH-1:0] redirect_offset,
    input  logic                         redirect_taken,
    input  logic [`VADDR_SIZE-1:0]       redirect_target,
    input  br_type_e                     redirect_br_type,
    input  logic [`COMMIT_NUM_WIDTH-1:0] commit_num,
    // squash and update to the predictor
    output logic                         squash,
    output logic [`VADDR_SIZE-1:0]       squash_target,
    output logic                         update_valid,
    output update_t                      update_info
);

    fsq_idx_t               tail;
    fsq_idx_t               search;
    fsq_idx_t               head;
    logic                   full;
    logic                   search_valid;
    logic                   head_valid;
    logic                   issue_ok;
    logic                   retire;
    logic                   queue_we;
    logic                   redirect_valid;
    logic                   refetch_next;
    logic [`FSQ_WIDTH-1:0]  search_addr;
    fetch_stream_t          search_stream;
    fetch_stream_t          commit_stream;
    logic [`VADDR_SIZE-1:0] mem_target;

    assign redirect_valid = redirect_kind != redir_none;
    assign refetch_next   = (redirect_kind == redir_branch) || (redirect_kind == redir_csr);
    assign queue_we       = bpu_en && !full;

    assign bpu_stall      = full;
    assign bpu_stream_idx = tail;

    // redirected block is read through the search port
    assign search_addr = redirect_valid ? redirect_idx.idx : search.idx;

    fsq_pointers u_pointers (
        .clk           (clk),
        .rst           (rst),
        .enq           (bpu_en),
        .issue_ok      (issue_ok),
        .retire        (retire),
        .redirect_kind (redirect_kind),
        .redirect_idx  (redirect_idx),
        .tail          (tail),
        .search        (search),
        .head          (head),
        .full          (full),
        .search_valid  (search_valid),
        .head_valid    (head_valid)
    );

    fsq_stream_ram u_stream_ram (
        .clk           (clk),
        .rst           (rst),
        .we            (queue_we),
        .waddr         (tail.idx),
        .wdata         (bpu_stream),
        .search_addr   (search_addr),
        .commit_addr   (head.idx),
        .search_stream (search_stream),
        .commit_stream (commit_stream)
    );

    fsq_fetch_issue u_fetch_issue (
        .clk           (clk),
        .rst           (rst),
        .search        (search),
        .search_valid  (search_valid),
        .search_stream (search_stream),
        .cache_ready   (cache_ready),
        .ibuf_full     (ibuf_full),
        .flush         (redirect_valid),
        .cache_en      (cache_en),
        .cache_stream  (cache_stream),
        .cache_fsq_idx (cache_fsq_idx),
        .issue_ok      (issue_ok),
        .cache_flush   (cache_flush)
    );

    fsq_commit u_commit (
        .clk              (clk),
        .rst              (rst),
        .enq              (queue_we),
        .enq_idx          (tail.idx),
        .redirect_kind    (redirect_kind),
        .redirect_idx     (redirect_idx),
        .redirect_offset  (redirect_offset),
        .redirect_taken   (redirect_taken),
        .redirect_target  (redirect_target),
        .redirect_br_type (redirect_br_type),
        .commit_num       (commit_num),
        .head             (head),
        .head_valid       (head_valid),
        .commit_stream    (commit_stream),
        .retire           (retire),
        .update_valid     (update_valid),
        .update_info      (update_info)
    );

    // refetch pc of the faulting instruction
    assign mem_target = search_stream.start_addr +
                        {{(`VADDR_SIZE-`PREDICTION_WIDTH-2){1'b0}}, redirect_offset, 2'b00};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            squash <= 1'b0;
        end else begin
            squash <= redirect_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (redirect_valid) begin
            squash_target <= refetch_next ? redirect_target : mem_target;
        end
    end

endmodule

// File: test/fsq_asserts.sv
`timescale 1ns/1ps

module fsq_asserts import fsq_pkg::*; (
    input logic           clk,
    input logic           rst,
    input logic           cache_en,
    input logic           cache_ready,
    input logic           ibuf_full,
    input logic           cache_flush,
    input fetch_stream_t  cache_stream,
    input fsq_idx_t       cache_fsq_idx,
    input logic           bpu_stall,
    input fsq_idx_t       bpu_stream_idx,
    input redirect_kind_e redirect_kind
);

    int   failures = 0;
    logic waiting;

    // request pending at the cache and not withdrawn
    assign waiting = cache_en && !(cache_ready && !ibuf_full) && !cache_flush;

    request_held: assert property (
        @(posedge clk) disable iff (rst)
        waiting |=> cache_en && $stable(cache_stream) && $stable(cache_fsq_idx)
    ) else begin
        failures++;
        $error("cache request changed before it was accepted");
    end

    tail_held: assert property (
        @(posedge clk) disable iff (rst)
        bpu_stall && redirect_kind == redir_none |=> $stable(bpu_stream_idx)
    ) else begin
        failures++;
        $error("bpu_stream_idx moved while the queue was full");
    end

    // a flush withdraws whatever request was pending
    flush_withdraw: assert property (
        @(posedge clk) disable iff (rst)
        cache_flush |=> !cache_en
    ) else begin
        failures++;
        $error("cache request still pending after a flush");
    end

endmodule

// File: test/fsq_tb.sv
`timescale 1ns/1ps
`include "fsq_defines.svh"

module fsq_tb import fsq_pkg::*; ();

    localparam int run_blocks  = 560;
    // about 600 blocks at a generous 32 cycles each, plus reset
    localparam int cycle_limit = 32 * (run_blocks + 40) + 800;

    logic                         clk;
    logic                         rst;
    logic                         bpu_en;
    fetch_stream_t                bpu_stream;
    logic                         bpu_stall;
    fsq_idx_t                     bpu_stream_idx;
    logic                         cache_en;
    fetch_stream_t                cache_stream;
    fsq_idx_t                     cache_fsq_idx;
    logic                         cache_flush;
    logic                         cache_ready;
    logic                         ibuf_full;
    redirect_kind_e               redirect_kind;
    fsq_idx_t                     redirect_idx;
    logic [`PREDICTION_WIDTH-1:0] redirect_offset;
    logic                         redirect_taken;
    logic [`VADDR_SIZE-1:0]       redirect_target;
    br_type_e                     redirect_br_type;
    logic [`COMMIT_NUM_WIDTH-1:0] commit_num;
    logic                         squash;
    logic [`VADDR_SIZE-1:0]       squash_target;
    logic                         update_valid;
    update_t                      update_info;

    // queue model
    fetch_stream_t model_stream [`FSQ_SIZE];
    wb_info_t      model_wb [`FSQ_SIZE];
    fsq_idx_t      model_tail = '0;
    fsq_idx_t      model_search = '0;
    fsq_idx_t      model_head = '0;
    // fetched instructions the back end has not committed yet
    int            pending = 0;
    logic          commit_en = 1'b0;
    logic [31:0]   rng_state = 32'hdf55;
    int            err_value = 0;
    int            err_other = 0;
    int            cycles = 0;

    fsq u_dut (.*);

    bind fsq fsq_asserts u_asserts (.*);

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic fetch_stream_t rand_stream();
        fetch_stream_t s;
        logic [31:0]   r;
        r = next_rand();
        s.start_addr = {r[31:2], 2'b00};
        r = next_rand();
        s.target = {r[31:2], 2'b00};
        s.taken  = r[0];
        r = next_rand();
        s.size = r[2:0];
        return s;
    endfunction

    // expected predictor update for one retired block
    function automatic update_t update_ref(input fetch_stream_t s, input wb_info_t wb);
        update_t u;
        u.start_addr = s.start_addr;
        u.pred_error = wb.pred_error;
        if (wb.pred_error) begin
            u.target  = wb.target;
            u.taken   = wb.taken;
            u.br_type = wb.br_type;
            u.offset  = wb.offset;
        end else begin
            u.target  = s.target;
            u.taken   = s.taken;
            u.br_type = br_direct;
            u.offset  = s.size;
        end
        return u;
    endfunction

    function automatic logic [31:0] squash_ref(input redirect_kind_e kind, input fsq_idx_t idx,
                                               input logic [2:0] off, input logic [31:0] tgt);
        if (kind == redir_mem) begin
            return model_stream[idx.idx].start_addr + 4 * off;
        end
        return tgt;
    endfunction

    task automatic check_stream(input string name, input fetch_stream_t got,
                                input fetch_stream_t exp);
        if (got !== exp) begin
            err_value++;
            $display("** Error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_idx(input string name, input fsq_idx_t got, input fsq_idx_t exp);
        if (got !== exp) begin
            err_value++;
            $display("** Error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_update(input string name, input update_t got, input update_t exp);
        if (got !== exp) begin
            err_value++;
            $display("** Error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_target(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            err_value++;
            $display("** Error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            err_value++;
            $display("** Error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic enqueue_block(input fetch_stream_t s, output fsq_idx_t idx);
        @(posedge clk);
        bpu_en     <= 1'b1;
        bpu_stream <= s;
        @(negedge clk);
        while (bpu_stall) begin
            @(negedge clk);
        end
        check_idx("bpu_stream_idx", bpu_stream_idx, model_tail);
        idx = model_tail;
        @(posedge clk);
        bpu_en <= 1'b0;
        model_stream[idx.idx] = s;
        model_wb[idx.idx]     = '0;
        model_tail            = fsq_idx_t'(model_tail + 1'b1);
    endtask

    task automatic drain();
        commit_en = 1'b1;
        wait (pending == 0 && model_head == model_tail);
        repeat (2) @(posedge clk);
    endtask

    task automatic redirect_test(input redirect_kind_e kind);
        fsq_idx_t                     ids [6];
        fsq_idx_t                     ridx;
        fsq_idx_t                     dummy;
        logic [`PREDICTION_WIDTH-1:0] off;
        logic [31:0]                  r;
        logic [2:0]                   bt;
        int                           kept;
        drain();
        commit_en = 1'b0;
        for (int i = 0; i < 6; i++) begin
            enqueue_block(rand_stream(), ids[i]);
        end
        ridx = ids[2];
        r    = next_rand();
        off  = r % (model_stream[ridx.idx].size + 1);
        r    = next_rand();
        bt   = r[7:5] % 3'd5;
        wait (model_search == model_tail);
        @(posedge clk);
        redirect_kind    <= kind;
        redirect_idx     <= ridx;
        redirect_offset  <= off;
        redirect_taken   <= r[0];
        redirect_target  <= r;
        redirect_br_type <= br_type_e'(bt);
        @(negedge clk);
        check_bit("cache_flush", cache_flush, 1'b1);
        @(posedge clk);
        redirect_kind <= redir_none;
        model_wb[ridx.idx] = '{pred_error: kind != redir_mem, taken: r[0],
                               br_type: br_type_e'(bt), offset: off, target: r};
        // younger blocks are dropped, a memory refetch is fetched again
        kept = model_stream[ids[0].idx].size + model_stream[ids[1].idx].size + 2;
        if (kind != redir_mem) begin
            kept = kept + off + 1;
        end
        pending      = kept;
        model_tail   = fsq_idx_t'(ridx + 1'b1);
        model_search = (kind == redir_mem) ? ridx : fsq_idx_t'(ridx + 1'b1);
        @(negedge clk);
        check_bit("squash", squash, 1'b1);
        check_target("squash_target", squash_target, squash_ref(kind, ridx, off, r));
        commit_en = 1'b1;
        repeat (16) enqueue_block(rand_stream(), dummy);
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // cache and instruction buffer back-pressure
    initial begin
        logic [31:0] r;
        forever begin
            @(posedge clk);
            r = next_rand();
            cache_ready <= r[0] | r[1];
            ibuf_full   <= (r[4:2] == 3'd0);
        end
    end

    // back end commits only instructions already fetched
    initial begin
        int n;
        forever begin
            @(posedge clk);
            n = 0;
            if (commit_en && !rst) begin
                n = next_rand() % 5;
                if (n > pending) begin
                    n = pending;
                end
            end
            commit_num <= `COMMIT_NUM_WIDTH'(n);
            pending = pending - n;
        end
    end

    // compare cache requests and predictor updates against the model
    initial begin
        forever begin
            @(negedge clk);
            if (!rst && cache_en && cache_ready && !ibuf_full && !cache_flush) begin
                check_idx("cache_fsq_idx", cache_fsq_idx, model_search);
                check_stream("cache_stream", cache_stream, model_stream[model_search.idx]);
                pending      = pending + model_stream[model_search.idx].size + 1;
                model_search = fsq_idx_t'(model_search + 1'b1);
            end
            if (!rst && update_valid) begin
                check_update("update_info", update_info,
                             update_ref(model_stream[model_head.idx], model_wb[model_head.idx]));
                model_head = fsq_idx_t'(model_head + 1'b1);
            end
        end
    end

    initial begin
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        err_other = err_other + 1 + u_dut.u_asserts.failures;
        $display("timeout: run stopped after %0d cycles", cycles);
        $display("errors: %0d value, %0d other", err_value, err_other);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        fsq_idx_t idx;
        fsq_idx_t wrapped;
        rst              = 1'b1;
        bpu_en           = 1'b0;
        bpu_stream       = '0;
        cache_ready      = 1'b0;
        ibuf_full        = 1'b0;
        redirect_kind    = redir_none;
        redirect_idx     = '0;
        redirect_offset  = '0;
        redirect_taken   = 1'b0;
        redirect_target  = '0;
        redirect_br_type = br_direct;
        commit_num       = '0;
        wrapped          = '{wrap: 1'b1, idx: '0};
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_bit("cache_en", cache_en, 1'b0);
        check_bit("squash", squash, 1'b0);
        check_bit("update_valid", update_valid, 1'b0);
        check_bit("bpu_stall", bpu_stall, 1'b0);
        check_idx("bpu_stream_idx", bpu_stream_idx, '0);
        // fill the ring while nothing commits
        repeat (`FSQ_SIZE) enqueue_block(rand_stream(), idx);
        @(negedge clk);
        check_bit("bpu_stall", bpu_stall, 1'b1);
        check_idx("bpu_stream_idx", bpu_stream_idx, wrapped);
        commit_en = 1'b1;
        repeat (run_blocks) enqueue_block(rand_stream(), idx);
        redirect_test(redir_branch);
        redirect_test(redir_mem);
        drain();
        err_other = err_other + u_dut.u_asserts.failures;
        $display("errors: %0d value, %0d other", err_value, err_other);
        if (err_value + err_other == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+include
source/fsq_pkg.sv
source/fsq_stream_ram.sv
source/fsq_pointers.sv
source/fsq_fetch_issue.sv
source/fsq_commit.sv
source/fsq.sv
test/fsq_asserts.sv
test/fsq_tb.sv

// File: Bender.yml
package:
  name: fsq

export_include_dirs:
  - include

sources:
  - files:
      - source/fsq_pkg.sv
      - source/fsq_stream_ram.sv
      - source/fsq_pointers.sv
      - source/fsq_fetch_issue.sv
      - source/fsq_commit.sv
      - source/fsq.sv
  - target: test
    files:
      - test/fsq_asserts.sv
      - test/fsq_tb.sv
